// File: rtl/rf_pkg.sv
//**************************************************
// register file package: widths, address and
// code word types, SEC-DED (39,32) check-bit encoder
//**************************************************
`default_nettype none

package rf_pkg;

   localparam int XLEN = 32;                        // data bits per register
   localparam int CHKW = 7;                         // 6 hamming bits + overall parity
   localparam int CWW  = XLEN + CHKW;               // stored code word width
   localparam int NREG = 32;                        // x0 .. x31

   typedef logic [4:0] rf_add;                      // register index

   typedef struct packed {
      logic [CHKW-1:0] chk;                         // [6] overall parity, [5:0] hamming
      logic [XLEN-1:0] data;
   } rf_cw;

   // data bit k sits at the k-th hamming position that is not a power of two,
   // so positions 3,5,6,7,9 .. 38 carry data and each hamming bit j covers
   // every position with bit j set
   function automatic rf_cw rf_encode(input logic [XLEN-1:0] data);
      rf_cw cw;
      logic [CHKW-2:0] hchk;
      int unsigned k;
      hchk = '0;
      k = 0;
      for (int unsigned p = 1; p < CWW; p++) begin
         if ((p & (p - 1)) != 0) begin              // skip check-bit positions
            if (data[k]) begin
               hchk ^= p[CHKW-2:0];                 // column of this data bit
            end
            k++;
         end
      end
      cw.data = data;
      cw.chk  = {^{hchk, data}, hchk};              // even parity over all 39 bits
      return cw;
   endfunction

endpackage

`default_nettype wire

// File: rtl/rf_wr_if.sv
//**************************************************
// write port of the register array
//**************************************************
`timescale 1ns/1ns
`default_nettype none

interface rf_wr_if (
   input logic clk                                  // register file clock
);

   logic          we;                               // write enable without handshake
   rf_pkg::rf_add add;                              // target register
   rf_pkg::rf_cw  cw;                               // encoded word to store

   modport master (output we, add, cw);
   modport slave  (input we, add, cw, clk);

endinterface

`default_nettype wire

// File: rtl/secded_dec.sv
//**************************************************
// SEC-DED (39,32) decoder for one read port
// single-bit correction, double-bit detection
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module secded_dec (
   input  rf_pkg::rf_cw              cw_i,          // stored code word
   output logic [rf_pkg::XLEN-1:0]   data_o,        // corrected data
   output logic                      ce_o,          // correctable error
   output logic                      uce_o          // uncorrectable error
);

   rf_pkg::rf_cw                  s_recalc;         // check bits rebuilt from data
   logic [rf_pkg::CHKW-2:0]       s_syn;            // hamming syndrome
   logic                          s_par_err;        // overall parity mismatch

   always_comb begin
      rf_pkg::rf_cw            col;
      logic [rf_pkg::XLEN-1:0] unit;
      s_recalc  = rf_pkg::rf_encode(cw_i.data);
      s_syn     = s_recalc.chk[rf_pkg::CHKW-2:0] ^ cw_i.chk[rf_pkg::CHKW-2:0];
      s_par_err = ^cw_i;                             // odd number of flipped bits
      data_o    = cw_i.data;
      // syndrome equals the hamming position of the faulty bit, so compare it
      // against the column of every data bit and flip the one that matches
      for (int i = 0; i < rf_pkg::XLEN; i++) begin
         unit    = '0;
         unit[i] = 1'b1;
         col     = rf_pkg::rf_encode(unit);          // constant, folds away
         if (s_par_err && (col.chk[rf_pkg::CHKW-2:0] == s_syn)) begin
            data_o[i] = ~cw_i.data[i];
         end
      end
      ce_o  = s_par_err;                             // also covers a check-bit hit
      uce_o = !s_par_err && (s_syn != '0);           // even flips, syndrome set
   end

   always_comb begin
      a_flags_excl: assert (!(ce_o && uce_o));
   end

endmodule

`default_nettype wire

// File: rtl/gpr_file.sv
//**************************************************
// 32 x 39-bit register array, one write port,
// two asynchronous read ports, upset injection
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module gpr_file (
   input  logic          s_clk_i,                   // clock
   input  logic          rst_i,                     // sync reset, active high
   rf_wr_if.slave        wr,                        // write port from the arbiter
   input  rf_pkg::rf_add ra_i [2],                  // read addresses
   output rf_pkg::rf_cw  q_o [2],                   // raw code words
   input  logic          seu_we_i,                  // inject upset
   input  rf_pkg::rf_add seu_add_i,                 // register to corrupt
   input  rf_pkg::rf_cw  seu_mask_i                 // bits to flip
);

   rf_pkg::rf_cw s_mem [rf_pkg::NREG];              // code word storage
   rf_pkg::rf_cw s_seu_base;                        // word the mask lands on
   logic         s_wr_ok;                           // write to a real register

   assign s_wr_ok = wr.we && (wr.add != '0);        // x0 is hardwired

   // an upset in the same edge as a write corrupts the freshly written word
   assign s_seu_base = (s_wr_ok && (wr.add == seu_add_i)) ? wr.cw : s_mem[seu_add_i];

   always_ff @(posedge s_clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < rf_pkg::NREG; i++) begin
            s_mem[i] <= rf_pkg::rf_encode('0);      // every register reads zero
         end
      end else begin
         if (s_wr_ok) begin
            s_mem[wr.add] <= wr.cw;
         end
         if (seu_we_i && (seu_add_i != '0)) begin
            s_mem[seu_add_i] <= s_seu_base ^ seu_mask_i;   // later nba wins
         end
      end
   end

   always_comb begin
      for (int p = 0; p < 2; p++) begin
         if (ra_i[p] == '0) begin
            q_o[p] = rf_pkg::rf_encode('0);         // x0 always zero
         end else begin
            q_o[p] = s_mem[ra_i[p]];
         end
      end
   end

   // neither the write port nor upset injection may ever touch x0
   a_x0_const: assert property (@(posedge s_clk_i) disable iff (rst_i) $stable(s_mem[0]));

endmodule

`default_nettype wire

// File: rtl/rf_acm.sv
//**************************************************
// write port arbiter: write-back first, then the
// one pending scrub of a corrected register
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module rf_acm (
   input  logic                    s_clk_i,         // clock
   input  logic                    rst_i,           // sync reset, active high
   input  logic                    wb_valid_i,      // result from WB stage
   input  rf_pkg::rf_add           wb_add_i,        // destination register
   input  logic [rf_pkg::XLEN-1:0] wb_val_i,        // result value
   input  rf_pkg::rf_add           ra_i [2],        // read addresses of both ports
   input  logic [rf_pkg::XLEN-1:0] rd_val_i [2],    // corrected read data
   input  logic [1:0]              ce_i,            // correctable error per port
   rf_wr_if.master                 wr               // array write port
);

   logic                    s_pend_q;               // correction waiting for the port
   rf_pkg::rf_add           s_pend_add_q;           // register to scrub
   logic [rf_pkg::XLEN-1:0] s_pend_val_q;           // corrected value
   logic                    s_cap;                  // record a correction this edge
   logic                    s_cap_sel;              // port being recorded
   logic [rf_pkg::XLEN-1:0] s_wr_val;               // unencoded write data

   always_comb begin
      s_cap_sel = !(ce_i[0] && (ra_i[0] != '0));    // port 1 has priority
      // a write-back to the same register this edge makes the correction stale
      s_cap = ce_i[s_cap_sel] && (ra_i[s_cap_sel] != '0) && !s_pend_q
              && !(wb_valid_i && (wb_add_i == ra_i[s_cap_sel]));
   end

   always_ff @(posedge s_clk_i) begin
      if (rst_i) begin
         s_pend_q <= 1'b0;
      end else if (s_cap) begin
         s_pend_q <= 1'b1;
      end else if (!wb_valid_i || (wb_add_i == s_pend_add_q)) begin
         s_pend_q <= 1'b0;                          // drained or overwritten
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (s_cap) begin
         s_pend_add_q <= ra_i[s_cap_sel];
         s_pend_val_q <= rd_val_i[s_cap_sel];
      end
   end

   always_comb begin
      wr.we    = wb_valid_i || s_pend_q;            // scrub only on idle write-back
      wr.add   = wb_valid_i ? wb_add_i : s_pend_add_q;
      s_wr_val = wb_valid_i ? wb_val_i : s_pend_val_q;
      wr.cw    = rf_pkg::rf_encode(s_wr_val);
   end

   // back-pressure keeps the correction waiting, it is not written under write-back
   a_scrub_deferred: assert property (@(posedge s_clk_i) disable iff (rst_i)
      (s_pend_q && wb_valid_i && (wb_add_i != s_pend_add_q)) |=> s_pend_q);

   a_pend_rst: assert property (@(posedge s_clk_i) rst_i |=> !s_pend_q);

endmodule

`default_nettype wire

// File: rtl/rf_controller.sv
//**************************************************
// SEC-DED protected integer register file top
// array, two port decoders and scrub arbiter
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module rf_controller (
   input  logic                    s_clk_i,         // clock
   input  logic                    rst_i,           // sync reset, active high
   input  logic                    wb_valid_i,      // write-back valid
   input  rf_pkg::rf_add           wb_add_i,        // write-back destination
   input  logic [rf_pkg::XLEN-1:0] wb_val_i,        // write-back value
   input  rf_pkg::rf_add           r_p1_add_i,      // read port 1 address
   input  rf_pkg::rf_add           r_p2_add_i,      // read port 2 address
   input  logic                    seu_we_i,        // upset injection enable
   input  rf_pkg::rf_add           seu_add_i,       // upset target register
   input  rf_pkg::rf_cw            seu_mask_i,      // stored bits to flip
   output logic [rf_pkg::XLEN-1:0] p1_val_o,        // read value port 1
   output logic [rf_pkg::XLEN-1:0] p2_val_o,        // read value port 2
   output logic [1:0]              ce_o,            // correctable, bit 0 is port 1
   output logic [1:0]              uce_o            // uncorrectable, bit 0 is port 1
);

   rf_pkg::rf_add           s_rp_add [2];           // read addresses
   rf_pkg::rf_cw            s_rp_cw [2];            // raw words from the array
   logic [rf_pkg::XLEN-1:0] s_rp_val [2];           // corrected data

   assign s_rp_add[0] = r_p1_add_i;
   assign s_rp_add[1] = r_p2_add_i;
   assign p1_val_o    = s_rp_val[0];
   assign p2_val_o    = s_rp_val[1];

   rf_wr_if m_wr_if (.clk(s_clk_i));

   gpr_file m_gpr (
      .s_clk_i    (s_clk_i),
      .rst_i      (rst_i),
      .wr         (m_wr_if.slave),
      .ra_i       (s_rp_add),
      .q_o        (s_rp_cw),
      .seu_we_i   (seu_we_i),
      .seu_add_i  (seu_add_i),
      .seu_mask_i (seu_mask_i)
   );

   for (genvar g = 0; g < 2; g++) begin : g_port
      secded_dec m_dec (
         .cw_i   (s_rp_cw[g]),
         .data_o (s_rp_val[g]),
         .ce_o   (ce_o[g]),
         .uce_o  (uce_o[g])
      );
   end

   // flags feed the arbiter directly, the scrub starts the edge after detection
   rf_acm m_acm (
      .s_clk_i    (s_clk_i),
      .rst_i      (rst_i),
      .wb_valid_i (wb_valid_i),
      .wb_add_i   (wb_add_i),
      .wb_val_i   (wb_val_i),
      .ra_i       (s_rp_add),
      .rd_val_i   (s_rp_val),
      .ce_i       (ce_o),
      .wr         (m_wr_if.master)
   );

endmodule

`default_nettype wire

// File: testbench/tb_rf_controller.sv
//**************************************************
// testbench for the SEC-DED register file: model,
// directed tests for reads, upsets and scrubbing
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_rf_controller;

   localparam int SCRUB_TIMEOUT = 20;               // cycles allowed for a scrub to land

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    wb_valid;
   rf_pkg::rf_add           wb_add;
   logic [rf_pkg::XLEN-1:0] wb_val;
   rf_pkg::rf_add           p1_add;
   rf_pkg::rf_add           p2_add;
   logic                    seu_we;
   rf_pkg::rf_add           seu_add;
   rf_pkg::rf_cw            seu_mask;
   logic [rf_pkg::XLEN-1:0] p1_val;
   logic [rf_pkg::XLEN-1:0] p2_val;
   logic [1:0]              ce;
   logic [1:0]              uce;

   logic [rf_pkg::XLEN-1:0] model [rf_pkg::NREG];   // expected register contents
   int                      n_chk;                  // checks done
   int                      n_err;                  // checks failed

   always #2 clk = ~clk;                            // 4 ns period

   rf_controller i_dut (
      .s_clk_i    (clk),
      .rst_i      (rst),
      .wb_valid_i (wb_valid),
      .wb_add_i   (wb_add),
      .wb_val_i   (wb_val),
      .r_p1_add_i (p1_add),
      .r_p2_add_i (p2_add),
      .seu_we_i   (seu_we),
      .seu_add_i  (seu_add),
      .seu_mask_i (seu_mask),
      .p1_val_o   (p1_val),
      .p2_val_o   (p2_val),
      .ce_o       (ce),
      .uce_o      (uce)
   );

   // random register x1 .. x31
   function automatic rf_pkg::rf_add pick_reg();
      return rf_pkg::rf_add'(1 + ($urandom % 31));
   endfunction

   function automatic logic [rf_pkg::CWW-1:0] bit_mask(input int pos);
      logic [rf_pkg::CWW-1:0] m;
      m    = '0;
      m[0] = 1'b1;
      return m << pos;                              // one stored bit to flip
   endfunction

   // start a cycle at the falling edge with all inputs idle
   task automatic next_cycle();
      @(negedge clk);
      wb_valid = 1'b0;
      seu_we   = 1'b0;
      seu_mask = '0;
      p1_add   = '0;
      p2_add   = '0;
   endtask

   task automatic write_back(input rf_pkg::rf_add addr, input logic [rf_pkg::XLEN-1:0] val);
      wb_valid = 1'b1;
      wb_add   = addr;
      wb_val   = val;
      if (addr != '0) begin
         model[addr] = val;                         // x0 stays zero
      end
   endtask

   task automatic inject_upset(input rf_pkg::rf_add addr, input logic [rf_pkg::CWW-1:0] mask);
      seu_we   = 1'b1;
      seu_add  = addr;
      seu_mask = mask;                              // lands at the next rising edge
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_chk++;
      assert (got === exp) else begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         n_err++;
      end
   endtask

   task automatic check_flags(input logic [1:0] exp_ce, input logic [1:0] exp_uce);
      check_eq("ce_o", 32'(ce), 32'(exp_ce));
      check_eq("uce_o", 32'(uce), 32'(exp_uce));
   endtask

   // sampled 1 ns before the rising edge once reads have settled
   task automatic check_reads(input logic [31:0] exp1, input logic [31:0] exp2,
                              input logic [1:0] exp_ce, input logic [1:0] exp_uce);
      #1;
      check_eq("p1_val_o", p1_val, exp1);
      check_eq("p2_val_o", p2_val, exp2);
      check_flags(exp_ce, exp_uce);
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("%s finished with %0d errors", name, n_err - err_before);
   endtask

   task automatic test_write_read();
      int            e0;
      rf_pkg::rf_add a;
      rf_pkg::rf_add b;
      e0 = n_err;
      for (int i = 0; i < rf_pkg::NREG; i++) begin
         next_cycle();
         write_back(rf_pkg::rf_add'(i), $urandom);  // x0 included and must not stick
      end
      for (int i = 0; i < rf_pkg::NREG; i++) begin
         next_cycle();
         a      = rf_pkg::rf_add'(i);
         b      = rf_pkg::rf_add'(31 - i);
         p1_add = a;
         p2_add = b;
         check_reads(model[a], model[b], 2'b00, 2'b00);
      end
      report_test("write_read", e0);
   endtask

   task automatic test_single_upset();
      int            e0;
      rf_pkg::rf_add r;
      e0 = n_err;
      r  = pick_reg();
      next_cycle();
      inject_upset(r, bit_mask(int'($urandom % rf_pkg::CWW)));
      next_cycle();
      p1_add = r;
      check_reads(model[r], 32'h0, 2'b01, 2'b00);   // corrected on port 1 only
      next_cycle();                                 // idle cycle writes the scrub
      next_cycle();
      p1_add = r;
      p2_add = r;
      check_reads(model[r], model[r], 2'b00, 2'b00);
      report_test("single_upset", e0);
   endtask

   task automatic test_double_upset();
      int            e0;
      int            pos1;
      int            pos2;
      rf_pkg::rf_add r;
      e0   = n_err;
      r    = pick_reg();
      pos1 = int'($urandom % rf_pkg::CWW);
      pos2 = (pos1 + 1 + int'($urandom % (rf_pkg::CWW - 1))) % rf_pkg::CWW;   // distinct bit
      next_cycle();
      inject_upset(r, bit_mask(pos1) | bit_mask(pos2));
      next_cycle();
      p1_add = r;
      p2_add = r;
      #1;
      check_flags(2'b00, 2'b11);                    // detected on both ports, no correction
      next_cycle();
      write_back(r, $urandom);                      // repair for the later tests
      next_cycle();
      p2_add = r;
      check_reads(32'h0, model[r], 2'b00, 2'b00);
      report_test("double_upset", e0);
   endtask

   task automatic test_back_pressure();
      int            e0;
      int            n;
      logic          landed;
      rf_pkg::rf_add r;
      rf_pkg::rf_add a;
      e0 = n_err;
      r  = pick_reg();
      next_cycle();
      inject_upset(r, bit_mask(int'($urandom % rf_pkg::CWW)));
      next_cycle();
      p1_add = r;
      check_reads(model[r], 32'h0, 2'b01, 2'b00);   // correction recorded here
      for (int k = 0; k < 6; k++) begin
         next_cycle();
         a = pick_reg();
         if (a == r) begin
            a = rf_pkg::rf_add'(a % 31 + 1);        // any other register
         end
         write_back(a, $urandom);
         p1_add = r;
         check_reads(model[r], 32'h0, 2'b01, 2'b00);   // still faulty while deferred
      end
      n      = 0;
      landed = 1'b0;
      while (!landed && n < SCRUB_TIMEOUT) begin
         next_cycle();
         p1_add = r;
         #1;
         landed = (ce[0] == 1'b0);
         n++;
      end
      n_chk++;
      assert (landed) else begin
         $display("scrub of x%0d did not land within %0d idle cycles", r, SCRUB_TIMEOUT);
         n_err++;
      end
      check_eq("p1_val_o", p1_val, model[r]);
      check_flags(2'b00, 2'b00);
      report_test("back_pressure", e0);
   endtask

   task automatic test_cancel_by_write();
      int                      e0;
      rf_pkg::rf_add           r;
      logic [rf_pkg::XLEN-1:0] nv;
      e0 = n_err;
      r  = pick_reg();
      nv = $urandom;
      if (nv == model[r]) begin
         nv = ~nv;                                  // must differ from the stale value
      end
      next_cycle();
      inject_upset(r, bit_mask(int'($urandom % rf_pkg::CWW)));
      next_cycle();
      p2_add = r;
      check_reads(32'h0, model[r], 2'b10, 2'b00);   // recorded from port 2
      next_cycle();
      write_back(r, nv);                            // newer value beats the pending scrub
      for (int k = 0; k < 3; k++) begin
         next_cycle();
         p1_add = r;
         p2_add = r;
         check_reads(nv, nv, 2'b00, 2'b00);
      end
      report_test("cancel_by_write", e0);
   endtask

   initial begin
      void'($urandom(44));
      rst      = 1'b1;
      wb_valid = 1'b0;
      wb_add   = '0;
      wb_val   = '0;
      p1_add   = '0;
      p2_add   = '0;
      seu_we   = 1'b0;
      seu_add  = '0;
      seu_mask = '0;
      n_chk    = 0;
      n_err    = 0;
      model    = '{default: '0};                    // reset value of every register
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_write_read();
      test_single_upset();
      test_double_upset();
      test_back_pressure();
      test_cancel_by_write();
      $display("checks %0d, errors %0d", n_chk, n_err);
      if (n_err == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
rtl/rf_pkg.sv
rtl/rf_wr_if.sv
rtl/secded_dec.sv
rtl/gpr_file.sv
rtl/rf_acm.sv
rtl/rf_controller.sv
testbench/tb_rf_controller.sv

// File: run.sh
#!/usr/bin/env bash
# build the register file testbench with Verilator, run it, scan the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rf_controller -f vlog.f -o sim_rf

./obj_dir/sim_rf 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
